// File: build.f
verilog/cpu_ctrl_pkg.sv
verilog/fetch_sequencer.sv
verilog/microcode_decoder.sv
verilog/microstep_sequencer.sv
verilog/control_unit.sv
verification/control_unit_assert.sv
verification/control_unit_tb.sv

// File: Bender.yml
package:
  name: cpu_control_unit

dependencies: {}

sources:
  # Package first, then the stages and the top level
  - verilog/cpu_ctrl_pkg.sv
  - verilog/fetch_sequencer.sv
  - verilog/microcode_decoder.sv
  - verilog/microstep_sequencer.sv
  - verilog/control_unit.sv
  - target: simulation
    files:
      - verification/control_unit_assert.sv
      - verification/control_unit_tb.sv

// File: verification/control_unit_tb.sv
`timescale 1ns/1ns

module control_unit_tb
    import cpu_ctrl_pkg::*;
();

    localparam int STEP_LIMIT = 8;   // Longest instruction is three steps

    logic          clk;
    logic          reset;
    opcode_t       opcode;           // Instruction register model
    logic [2:0]    flags;            // Status register model
    control_word_t control_word;
    logic          last_microstep;

    integer  seed;
    integer  check_count;
    integer  error_count;
    integer  test_count;
    integer  failed_tests;
    integer  test_start_errors;
    opcode_t next_op;

    control_unit uut (
        .clk            (clk),
        .reset          (reset),
        .opcode         (opcode),
        .flags          (flags),
        .control_word   (control_word),
        .last_microstep (last_microstep)
    );

    always #50 clk = ~clk;

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic int operand_bytes(input opcode_t op);
        case (op)
            JMP, JZ, JNZ, JC, JNC, JN, JNN: return 2;
            LDI_A, LDI_B, ANI, ORI, XRI:    return 1;
            default:                        return 0;
        endcase
    endfunction

    function automatic alu_op_t alu_operation(input opcode_t op);
        case (op)
            ADD_B, ADD_C:        return ALU_ADD;
            SUB_B, SUB_C, CMP_B: return ALU_SUB;
            ANA_B, ANI:          return ALU_AND;
            ORA_B, ORI:          return ALU_OR;
            XRA_B, XRI:          return ALU_XOR;
            INR_A:               return ALU_INR;
            DCR_A:               return ALU_DCR;
            RAR:                 return ALU_ROR;
            RAL:                 return ALU_ROL;
            CMA:                 return ALU_INV;
            default:             return ALU_UNDEFINED;
        endcase
    endfunction

    function automatic logic branch_taken(input opcode_t op, input logic [2:0] f);
        case (op)
            JZ:      return f[FLAG_ZERO];
            JNZ:     return !f[FLAG_ZERO];
            JC:      return f[FLAG_CARRY];
            JNC:     return !f[FLAG_CARRY];
            JN:      return f[FLAG_NEG];
            JNN:     return !f[FLAG_NEG];
            default: return 1'b1;   // JMP and everything else
        endcase
    endfunction

    // Phase 0 address latch, 1 read, 2 byte latch, 3 count check
    function automatic control_word_t fetch_cycle_word(input int phase, input int byte_idx);
        control_word_t w;
        w = '0;
        case (phase)
            0: w.load_mar_pc = 1'b1;
            1: w.oe_ram = 1'b1;
            2: begin
                w.oe_ram      = 1'b1;
                w.pc_enable   = 1'b1;
                w.load_ir     = (byte_idx == 0);
                w.load_temp_1 = (byte_idx == 1);
                w.load_temp_2 = (byte_idx == 2);
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic control_word_t microcode_word(input opcode_t op, input int step);
        control_word_t w;
        logic          immediate;
        int            write_step;
        w          = '0;
        immediate  = (op == ANI) || (op == ORI) || (op == XRI);
        write_step = (op == RAR) ? 2 : 1;   // RAR idles one step
        case (op)
            NOP: w.last_step = (step == 0);
            HLT: w.halt = (step == 0);
            JMP, JZ, JNZ, JC, JNC, JN, JNN: begin
                if (step == 0) begin
                    w.oe_temp_1          = 1'b1;
                    w.load_pc_low_byte   = 1'b1;
                    w.check_zero         = (op == JZ);
                    w.check_not_zero     = (op == JNZ);
                    w.check_carry        = (op == JC);
                    w.check_not_carry    = (op == JNC);
                    w.check_negative     = (op == JN);
                    w.check_not_negative = (op == JNN);
                end else if (step == 1) begin
                    w.oe_temp_2         = 1'b1;
                    w.load_pc_high_byte = 1'b1;
                    w.last_step         = 1'b1;
                end
            end
            CMP_B: begin
                if (step == 0) begin
                    w.alu_op = ALU_SUB;
                end else if (step == 1) begin
                    w.load_status = 1'b1;
                    w.last_step   = 1'b1;
                end
            end
            ADD_B, ADD_C, SUB_B, SUB_C, ANA_B, ORA_B, XRA_B,
            INR_A, DCR_A, RAR, RAL, CMA, ANI, ORI, XRI: begin
                if (step == 0) begin
                    w.alu_op         = alu_operation(op);
                    w.alu_src2_c     = (op == ADD_C) || (op == SUB_C);
                    w.oe_temp_1      = immediate;
                    w.alu_src2_temp1 = immediate;
                end else if (step == write_step) begin
                    w.oe_alu      = 1'b1;   // Result back into A
                    w.load_a      = 1'b1;
                    w.load_status = 1'b1;
                    w.last_step   = 1'b1;
                end
            end
            MOV_AB, MOV_BA: begin
                w.oe_a      = (step == 0) && (op == MOV_AB);
                w.load_b    = (step == 0) && (op == MOV_AB);
                w.oe_b      = (step == 0) && (op == MOV_BA);
                w.load_a    = (step == 0) && (op == MOV_BA);
                w.last_step = (step == 0);
            end
            LDI_A, LDI_B: begin
                w.oe_temp_1    = (step == 0);
                w.load_a       = (step == 0) && (op == LDI_A);
                w.load_b       = (step == 0) && (op == LDI_B);
                w.load_status  = (step == 0);
                w.load_sets_zn = (step == 0);
                w.last_step    = (step == 0);
            end
            SEC, CLC: begin
                w.set_carry_flag   = (step == 0) && (op == SEC);
                w.clear_carry_flag = (step == 0) && (op == CLC);
                w.load_status      = (step == 0);
                w.last_step        = (step == 0);
            end
            default: w.halt = (step == 0);   // Unknown opcode
        endcase
        return w;
    endfunction

    function automatic void step_expectation(input opcode_t op, input int step,
                                             input logic [2:0] f,
                                             output control_word_t w, output logic last);
        control_word_t first;
        logic          skip;
        first = microcode_word(op, 0);
        w     = microcode_word(op, step);
        skip  = (step == 0) && !branch_taken(op, f);
        if (step > 0) begin
            w.alu_op = first.alu_op;   // Step 0 operation held
        end
        if (skip) begin
            w.load_pc_low_byte = 1'b0;
        end
        last = w.last_step || w.halt || skip;
    endfunction

    // ========================================================================
    // Stimulus and checks
    // ========================================================================

    task automatic compare_outputs(input control_word_t exp_word, input logic exp_last,
                                   input string what);
        check_count = check_count + 1;
        assert (control_word === exp_word && last_microstep === exp_last) else begin
            $display("CHECK FAILED at %0t ns: %s, word %h expected %h, last %b expected %b",
                     $time, what, control_word, exp_word, last_microstep, exp_last);
            error_count = error_count + 1;
        end
    endtask

    // Check mid-cycle, return on the next rising edge
    task automatic expect_cycle(input control_word_t exp_word, input logic exp_last,
                                input string what);
        @(negedge clk);
        compare_outputs(exp_word, exp_last, what);
        @(posedge clk);
    endtask

    task automatic apply_reset();
        control_word_t init_word;
        init_word             = '0;
        init_word.load_origin = 1'b1;
        reset <= 1'b1;
        @(posedge clk);
        repeat (3) begin
            @(negedge clk);
            compare_outputs('0, 1'b0, "output during reset");
            @(posedge clk);
        end
        reset <= 1'b0;   // Fourth edge still sees reset high
        expect_cycle('0, 1'b0, "first cycle after reset");
        expect_cycle(init_word, 1'b0, "init cycle");
    endtask

    task automatic fetch_instruction(input opcode_t op);
        integer rnd;
        for (int b = 0; b <= operand_bytes(op); b++) begin
            expect_cycle(fetch_cycle_word(0, b), 1'b0, "address latch");
            expect_cycle(fetch_cycle_word(1, b), 1'b0, "memory read");
            expect_cycle(fetch_cycle_word(2, b), 1'b0, "byte latch");
            if (b == 0) begin
                rnd = $random(seed);
                opcode <= op;         // IR loads on this edge
                flags  <= rnd[2:0];
            end
            expect_cycle(fetch_cycle_word(3, b), 1'b0, "byte count check");
        end
    endtask

    task automatic execute_instruction(input opcode_t op);
        control_word_t exp_word;
        logic          exp_last;
        logic          seen_last;
        int            step;
        step      = 0;
        seen_last = 1'b0;
        while (!seen_last) begin
            if (step == STEP_LIMIT) begin
                $display("Timeout: opcode %0d gave no last microstep in %0d steps",
                         op, STEP_LIMIT);
                $display("Testbench failed");
                $finish;
            end
            step_expectation(op, step, flags, exp_word, exp_last);
            @(negedge clk);
            compare_outputs(exp_word, exp_last, $sformatf("opcode %0d step %0d", op, step));
            seen_last = (last_microstep === 1'b1);
            @(posedge clk);
            step = step + 1;
        end
    endtask

    task automatic run_instruction(input opcode_t op);
        fetch_instruction(op);
        execute_instruction(op);
    endtask

    task automatic expect_halted(input int cycles);
        repeat (cycles) begin
            expect_cycle('0, 1'b0, "halted");
        end
    endtask

    // Kind 0 data ops, 1 one operand, 2 jumps, 3 unrecognized
    task automatic random_opcode(input int kind, output opcode_t op);
        int unsigned r;
        int unsigned idx;
        r = $random(seed);
        case (kind)
            0: begin
                idx = r % 18;
                if (idx < 13) begin
                    op = opcode_t'(ADD_B + idx);
                end else if (idx < 15) begin
                    op = opcode_t'(MOV_AB + idx - 13);
                end else if (idx < 17) begin
                    op = opcode_t'(SEC + idx - 15);
                end else begin
                    op = NOP;
                end
            end
            1: begin
                idx = r % 5;
                op  = (idx < 3) ? opcode_t'(ANI + idx) : opcode_t'(LDI_A + idx - 3);
            end
            2:       op = opcode_t'(JMP + r % 7);
            default: op = opcode_t'(31 + r % 225);
        endcase
    endtask

    task automatic start_test();
        test_start_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count = test_count + 1;
        if (error_count == test_start_errors) begin
            $display("test %-12s ok", name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %-12s %0d errors", name, error_count - test_start_errors);
        end
    endtask

    initial begin
        seed         = 96253;
        clk          = 1'b0;
        reset        = 1'b1;
        opcode       = NOP;
        flags        = 3'b000;
        check_count  = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;

        start_test();
        apply_reset();
        run_instruction(NOP);
        finish_test("reset_init");

        start_test();
        for (int i = 0; i < 12; i++) begin
            random_opcode(i % 3, next_op);
            run_instruction(next_op);
        end
        finish_test("fetch");

        start_test();
        for (int i = 0; i < 40; i++) begin
            random_opcode((i % 4 == 3) ? 1 : 0, next_op);
            run_instruction(next_op);
        end
        finish_test("alu_data");

        start_test();
        for (int i = 0; i < 30; i++) begin
            random_opcode(2, next_op);
            run_instruction(next_op);
        end
        finish_test("jumps");

        start_test();
        run_instruction(HLT);
        expect_halted(12);
        apply_reset();
        run_instruction(LDI_A);
        run_instruction(ADD_B);
        random_opcode(3, next_op);
        run_instruction(next_op);
        expect_halted(12);
        finish_test("halt");

        error_count = error_count + uut.u_assert.failures;
        $display("tests %0d, failed %0d, checks %0d, assertion failures %0d, errors %0d",
                 test_count, failed_tests, check_count, uut.u_assert.failures, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verification/control_unit_assert.sv
`timescale 1ns/1ns

module control_unit_assert
    import cpu_ctrl_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input control_word_t control_word,
    input logic          last_microstep
);

    int unsigned failures = 0;
    logic        halted;         // Set once a halt step has gone by

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (control_word.halt) begin
            halted <= 1'b1;
        end
    end

    // ========================================================================
    // Control word properties
    // ========================================================================

    fetch_load_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({control_word.load_ir, control_word.load_temp_1, control_word.load_temp_2})
    ) else begin
        $error("more than one fetch destination loaded in one cycle");
        failures++;
    end

    // Jump target bytes come from the temp registers
    pc_load_source: assert property (@(posedge clk) disable iff (reset)
        (!control_word.load_pc_low_byte  || control_word.oe_temp_1) &&
        (!control_word.load_pc_high_byte || control_word.oe_temp_2)
    ) else begin
        $error("pc load without its temp register on the bus");
        failures++;
    end

    last_step_single: assert property (@(posedge clk) disable iff (reset)
        last_microstep |=> !last_microstep
    ) else begin
        $error("last_microstep high on two cycles in a row");
        failures++;
    end

    halt_is_final: assert property (@(posedge clk) disable iff (reset)
        halted |-> (control_word == '0) && !last_microstep
    ) else begin
        $error("control word active after a halt step");
        failures++;
    end

endmodule

bind control_unit control_unit_assert u_assert (
    .clk            (clk),
    .reset          (reset),
    .control_word   (control_word),
    .last_microstep (last_microstep)
);

// File: verilog/control_unit.sv
`timescale 1ns/1ns

module control_unit
    import cpu_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  opcode_t       opcode,
    input  logic [2:0]    flags,
    output control_word_t control_word,
    output logic          last_microstep
);

    logic          exec_active;
    logic          exec_done;
    logic          halt_taken;
    logic [1:0]    operand_count;
    microstep_t    microstep;
    control_word_t fetch_word;
    control_word_t rom_word;

    // Reset, init and byte fetch
    fetch_sequencer u_fetch (
        .clk           (clk),
        .reset         (reset),
        .operand_count (operand_count),
        .exec_done     (exec_done),
        .halt_taken    (halt_taken),
        .exec_active   (exec_active),
        .fetch_word    (fetch_word)
    );

    microcode_decoder u_decoder (
        .opcode        (opcode),
        .microstep     (microstep),
        .operand_count (operand_count),
        .rom_word      (rom_word)
    );

    // Execute stage owns the output word
    microstep_sequencer u_execute (
        .clk            (clk),
        .reset          (reset),
        .exec_active    (exec_active),
        .flags          (flags),
        .rom_word       (rom_word),
        .fetch_word     (fetch_word),
        .microstep      (microstep),
        .exec_done      (exec_done),
        .halt_taken     (halt_taken),
        .control_word   (control_word),
        .last_microstep (last_microstep)
    );

endmodule

// File: verilog/microstep_sequencer.sv
`timescale 1ns/1ns

module microstep_sequencer
    import cpu_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          exec_active,
    input  logic [2:0]    flags,
    input  control_word_t rom_word,
    input  control_word_t fetch_word,
    output microstep_t    microstep,
    output logic          exec_done,
    output logic          halt_taken,
    output control_word_t control_word,
    output logic          last_microstep
);

    alu_op_t alu_op_held;     // Step 0 operation held for later steps
    logic    any_check;
    logic    condition_met;
    logic    branch_not_taken;
    logic    step_ends;

    // =========================================================================
    // Branch evaluation
    // =========================================================================

    assign any_check = rom_word.check_zero  || rom_word.check_not_zero  ||
                       rom_word.check_carry || rom_word.check_not_carry ||
                       rom_word.check_negative || rom_word.check_not_negative;

    assign condition_met =
        (rom_word.check_zero         &&  flags[FLAG_ZERO])  ||
        (rom_word.check_not_zero     && !flags[FLAG_ZERO])  ||
        (rom_word.check_carry        &&  flags[FLAG_CARRY]) ||
        (rom_word.check_not_carry    && !flags[FLAG_CARRY]) ||
        (rom_word.check_negative     &&  flags[FLAG_NEG])   ||
        (rom_word.check_not_negative && !flags[FLAG_NEG]);

    assign branch_not_taken = any_check && !condition_met;

    // Halt, explicit last step or a failed condition end the instruction
    assign step_ends = rom_word.halt || rom_word.last_step || branch_not_taken;

    assign exec_done      = exec_active && step_ends;
    assign halt_taken     = exec_active && rom_word.halt;
    assign last_microstep = exec_done;

    // =========================================================================
    // Microstep counter and ALU latch
    // =========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            microstep <= 3'd0;
        end else if (exec_active) begin
            if (step_ends) begin
                microstep <= 3'd0;
            end else begin
                microstep <= microstep + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exec_active && (microstep == 3'd0)) begin
            alu_op_held <= rom_word.alu_op;
        end
    end

    // =========================================================================
    // Output select
    // =========================================================================

    always_comb begin
        if (exec_active) begin
            control_word = rom_word;
            if (microstep != 3'd0) begin
                control_word.alu_op = alu_op_held;   // Hold ALU steady past step 0
            end
            if (branch_not_taken) begin
                control_word.load_pc_low_byte  = 1'b0;   // Jump suppressed
                control_word.load_pc_high_byte = 1'b0;
            end
        end else begin
            control_word = fetch_word;
        end
    end

endmodule

// File: verilog/microcode_decoder.sv
`timescale 1ns/1ns

module microcode_decoder
    import cpu_ctrl_pkg::*;
(
    input  opcode_t       opcode,
    input  microstep_t    microstep,
    output logic [1:0]    operand_count,
    output control_word_t rom_word
);

    alu_op_t alu_sel;
    logic    step_0;
    logic    step_1;
    logic    step_2;
    logic    is_immediate;

    // Common write-back step of the accumulator ALU instructions
    function automatic control_word_t write_a_step();
        control_word_t w;
        w             = '0;
        w.oe_alu      = 1'b1;
        w.load_a      = 1'b1;
        w.load_status = 1'b1;
        w.last_step   = 1'b1;
        return w;
    endfunction

    assign step_0       = (microstep == 3'd0);
    assign step_1       = (microstep == 3'd1);
    assign step_2       = (microstep == 3'd2);
    assign is_immediate = (opcode == ANI) || (opcode == ORI) || (opcode == XRI);

    // =========================================================================
    // Operand bytes per opcode
    // =========================================================================

    always_comb begin
        case (opcode)
            JMP, JZ, JNZ, JC, JNC, JN, JNN: operand_count = 2'd2;   // Address low, high
            LDI_A, LDI_B, ANI, ORI, XRI:    operand_count = 2'd1;
            default:                        operand_count = 2'd0;   // Unknown too
        endcase
    end

    always_comb begin
        case (opcode)
            ADD_B, ADD_C:        alu_sel = ALU_ADD;
            SUB_B, SUB_C, CMP_B: alu_sel = ALU_SUB;
            ANA_B, ANI:          alu_sel = ALU_AND;
            ORA_B, ORI:          alu_sel = ALU_OR;
            XRA_B, XRI:          alu_sel = ALU_XOR;
            INR_A:               alu_sel = ALU_INR;
            DCR_A:               alu_sel = ALU_DCR;
            RAR:                 alu_sel = ALU_ROR;
            RAL:                 alu_sel = ALU_ROL;
            CMA:                 alu_sel = ALU_INV;
            default:             alu_sel = ALU_UNDEFINED;
        endcase
    end

    // =========================================================================
    // Microcode table
    // =========================================================================

    always_comb begin
        rom_word = '0;   // Unused steps stay empty

        case (opcode)
            NOP: rom_word.last_step = step_0;
            HLT: rom_word.halt      = step_0;
            JMP, JZ, JNZ, JC, JNC, JN, JNN: begin
                if (step_0) begin
                    rom_word.oe_temp_1          = 1'b1;
                    rom_word.load_pc_low_byte   = 1'b1;
                    rom_word.check_zero         = (opcode == JZ);
                    rom_word.check_not_zero     = (opcode == JNZ);
                    rom_word.check_carry        = (opcode == JC);
                    rom_word.check_not_carry    = (opcode == JNC);
                    rom_word.check_negative     = (opcode == JN);
                    rom_word.check_not_negative = (opcode == JNN);
                end else if (step_1) begin
                    rom_word.oe_temp_2         = 1'b1;
                    rom_word.load_pc_high_byte = 1'b1;
                    rom_word.last_step         = 1'b1;
                end
            end
            ADD_B, ADD_C, SUB_B, SUB_C, ANA_B, ORA_B, XRA_B,
            INR_A, DCR_A, RAL, CMA, ANI, ORI, XRI: begin
                if (step_0) begin
                    rom_word.alu_op         = alu_sel;
                    rom_word.alu_src2_c     = (opcode == ADD_C) || (opcode == SUB_C);
                    rom_word.oe_temp_1      = is_immediate;
                    rom_word.alu_src2_temp1 = is_immediate;
                end else if (step_1) begin
                    rom_word = write_a_step();
                end
            end
            CMP_B: begin
                if (step_0) begin
                    rom_word.alu_op = alu_sel;
                end else if (step_1) begin
                    rom_word.load_status = 1'b1;   // Flags only, A untouched
                    rom_word.last_step   = 1'b1;
                end
            end
            RAR: begin
                // Extra empty step before write-back
                if (step_0) begin
                    rom_word.alu_op = alu_sel;
                end else if (step_2) begin
                    rom_word = write_a_step();
                end
            end
            MOV_AB, MOV_BA: begin
                rom_word.oe_a      = step_0 && (opcode == MOV_AB);
                rom_word.oe_b      = step_0 && (opcode == MOV_BA);
                rom_word.load_b    = step_0 && (opcode == MOV_AB);
                rom_word.load_a    = step_0 && (opcode == MOV_BA);
                rom_word.last_step = step_0;
            end
            LDI_A, LDI_B: begin
                rom_word.oe_temp_1    = step_0;
                rom_word.load_a       = step_0 && (opcode == LDI_A);
                rom_word.load_b       = step_0 && (opcode == LDI_B);
                rom_word.load_status  = step_0;
                rom_word.load_sets_zn = step_0;
                rom_word.last_step    = step_0;
            end
            SEC, CLC: begin
                rom_word.set_carry_flag   = step_0 && (opcode == SEC);
                rom_word.clear_carry_flag = step_0 && (opcode == CLC);
                rom_word.load_status      = step_0;
                rom_word.last_step        = step_0;
            end
            default: rom_word.halt = step_0;   // Unrecognized opcode stops the CPU
        endcase
    end

endmodule

// File: verilog/fetch_sequencer.sv
`timescale 1ns/1ns

module fetch_sequencer
    import cpu_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic [1:0]    operand_count,
    input  logic          exec_done,
    input  logic          halt_taken,
    output logic          exec_active,
    output control_word_t fetch_word
);

    fetch_state_t state;
    fetch_state_t next_state;
    logic [1:0]   byte_count;      // Bytes of this instruction already latched
    logic [1:0]   next_byte_count;

    // =========================================================================
    // State registers
    // =========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            byte_count <= 2'd0;
        end else begin
            state      <= next_state;
            byte_count <= next_byte_count;
        end
    end

    assign exec_active = (state == S_EXECUTE);

    // =========================================================================
    // Next state and fetch word
    // =========================================================================

    always_comb begin
        next_state      = state;
        next_byte_count = byte_count;
        fetch_word      = '0;

        case (state)
            S_RESET: next_state = S_INIT;
            S_INIT: begin
                fetch_word.load_origin = 1'b1;   // PC to program origin
                next_state             = S_LATCH_ADDR;
            end
            S_LATCH_ADDR: begin
                fetch_word.load_mar_pc = 1'b1;
                next_state             = S_READ_BYTE;
            end
            S_READ_BYTE: begin
                fetch_word.oe_ram = 1'b1;        // Give RAM a cycle to settle
                next_state        = S_LATCH_BYTE;
            end
            S_LATCH_BYTE: begin
                fetch_word.oe_ram    = 1'b1;
                fetch_word.pc_enable = 1'b1;
                next_state           = S_CHK_MORE_BYTES;
                next_byte_count      = byte_count + 2'd1;
                case (byte_count)
                    2'd0:    fetch_word.load_ir     = 1'b1;
                    2'd1:    fetch_word.load_temp_1 = 1'b1;
                    2'd2:    fetch_word.load_temp_2 = 1'b1;
                    default: next_state             = S_HALT;   // Count overrun
                endcase
            end
            S_CHK_MORE_BYTES: begin
                // Opcode already updated from the load_ir edge
                if (byte_count > operand_count) begin
                    next_state      = S_EXECUTE;
                    next_byte_count = 2'd0;
                end else begin
                    next_state = S_LATCH_ADDR;
                end
            end
            S_EXECUTE: begin
                if (halt_taken) begin
                    next_state = S_HALT;
                end else if (exec_done) begin
                    next_state = S_LATCH_ADDR;
                end
            end
            S_HALT:  next_state = S_HALT;        // Only reset leaves
            default: next_state = S_HALT;
        endcase
    end

endmodule

// File: verilog/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // =========================================================================
    // Instruction set
    // =========================================================================

    localparam int OPCODE_WIDTH = 8;

    // Consecutive from zero and unrecognized from 31 up
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP,
        HLT,
        JMP,
        JZ,
        JNZ,
        JC,
        JNC,
        JN,
        JNN,
        ADD_B,
        ADD_C,
        SUB_B,
        SUB_C,
        ANA_B,
        ORA_B,
        XRA_B,
        CMP_B,
        INR_A,
        DCR_A,
        RAR,
        RAL,
        CMA,
        ANI,
        ORI,
        XRI,
        MOV_AB,
        MOV_BA,
        LDI_A,
        LDI_B,
        SEC,
        CLC
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_UNDEFINED,    // Must stay at zero
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_INR,
        ALU_DCR,
        ALU_ROR,
        ALU_ROL,
        ALU_INV
    } alu_op_t;

    // =========================================================================
    // Sequencing
    // =========================================================================

    typedef enum logic [2:0] {
        S_RESET,
        S_INIT,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } fetch_state_t;

    typedef logic [2:0] microstep_t;

    // Status register bit positions
    localparam int FLAG_ZERO  = 0;
    localparam int FLAG_CARRY = 1;
    localparam int FLAG_NEG   = 2;

    // =========================================================================
    // Control word
    // =========================================================================

    typedef struct packed {
        // Fetch
        logic    load_origin;
        logic    load_mar_pc;
        logic    oe_ram;
        logic    pc_enable;
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        // Operands and jump target
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        // Branch conditions
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_not_carry;
        logic    check_negative;
        logic    check_not_negative;
        // ALU
        alu_op_t alu_op;
        logic    alu_src2_c;
        logic    alu_src2_temp1;
        logic    oe_alu;
        // Registers
        logic    oe_a;
        logic    oe_b;
        logic    load_a;
        logic    load_b;
        // Status register
        logic    load_status;
        logic    load_sets_zn;     // Z and N from bus, not ALU
        logic    set_carry_flag;
        logic    clear_carry_flag;
        // Sequencing
        logic    halt;
        logic    last_step;
    } control_word_t;

endpackage
